/* pm_config.svh */
// packet memory configuration

`ifndef PM_CONFIG_SVH
`define PM_CONFIG_SVH

// ----------------------------------------------------------------------
// bank geometry
// ----------------------------------------------------------------------

// chunks per bank, lower half is chunks 0 .. PM_N_CHUNKS/2-1
`define PM_N_CHUNKS 4

// number of sector banks side by side
`define PM_N_SECTORS 2

// ----------------------------------------------------------------------
// chunk sram shape
// ----------------------------------------------------------------------

// word address per chunk, 64 words deep
`define PM_ADDR_W 6

// data bits per chunk word
`define PM_DATA_W 16

`endif

/* pm_pkg.sv */
// packet memory types

`default_nettype none

`include "pm_config.svh"

package pm_pkg;

  // ----------------------------------------------------------------------
  // scalar types
  // ----------------------------------------------------------------------

  // one chunk word address
  typedef logic [`PM_ADDR_W-1:0] pm_addr_t;

  // one chunk data word
  typedef logic [`PM_DATA_W-1:0] pm_data_t;

  // one bit per chunk in a bank
  typedef logic [`PM_N_CHUNKS-1:0] pm_chunk_mask_t;

  // one bit per sector bank
  typedef logic [`PM_N_SECTORS-1:0] pm_sect_mask_t;

  // ----------------------------------------------------------------------
  // control word, fanned out to every bank
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic           v;
    // one-hot sector select per half
    pm_sect_mask_t  sect_en_lower;
    pm_sect_mask_t  sect_en_upper;
    // per half, 1 = write, 0 = read
    pm_sect_mask_t  sect_rw_lower;
    pm_sect_mask_t  sect_rw_upper;
    // read and write addresses travel separately
    pm_addr_t       a_rd;
    pm_addr_t       a_wr;
    pm_chunk_mask_t en_rd;
    pm_chunk_mask_t en_wr;
  } pm_ctrl_t;

  // per-chunk read return from one bank
  typedef struct packed {
    pm_data_t [`PM_N_CHUNKS-1:0] d;
    // one-cycle strobe per chunk
    pm_chunk_mask_t              v;
  } pm_rd_bus_t;

endpackage

`default_nettype wire

/* pm_ctrl_if.sv */
// control word interface

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

interface pm_ctrl_if;

  import pm_pkg::*;

  // ----------------------------------------------------------------------
  // payload
  // ----------------------------------------------------------------------

  // control word, a level qualified by ctrl.v
  // lasts one cycle per request, no handshake
  pm_ctrl_t                    ctrl;

  // write data, one word per chunk
  // only meaningful while a write is flagged in ctrl
  pm_data_t [`PM_N_CHUNKS-1:0] w_data;

  // ----------------------------------------------------------------------
  // modports
  // ----------------------------------------------------------------------

  // command generator side
  modport gen (
    output ctrl,
    output w_data
  );

  // every sector bank listens on this side
  modport bank (
    input ctrl,
    input w_data
  );

endinterface

`default_nettype wire

/* pm_cmd_gen.sv */
// packet memory command generator

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_cmd_gen (
  input  logic                                  clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_req_v,
  input  logic                                  i_req_wr,
  input  logic [$clog2(`PM_N_SECTORS)-1:0]      i_req_sector,
  input  logic                                  i_req_upper,
  input  pm_pkg::pm_addr_t                      i_req_addr,
  input  pm_pkg::pm_chunk_mask_t                i_req_chunk_en,
  input  pm_pkg::pm_data_t [`PM_N_CHUNKS-1:0]   i_wr_data,
  pm_ctrl_if.gen                                o_ctrl
);

  import pm_pkg::*;

  pm_sect_mask_t sect_oh;
  pm_ctrl_t      ctrl_nxt;

  // ----------------------------------------------------------------------
  // request encode
  // ----------------------------------------------------------------------
  always_comb begin
    // one-hot sector select
    sect_oh = '0;
    sect_oh[i_req_sector] = 1'b1;

    ctrl_nxt   = '0;
    ctrl_nxt.v = i_req_v;

    // only the chosen half sees the sector
    if (i_req_upper) begin
      ctrl_nxt.sect_en_upper = sect_oh;
      ctrl_nxt.sect_rw_upper = i_req_wr ? sect_oh : '0;
    end else begin
      ctrl_nxt.sect_en_lower = sect_oh;
      ctrl_nxt.sect_rw_lower = i_req_wr ? sect_oh : '0;
    end

    // write fields or read fields, never both
    if (i_req_wr) begin
      ctrl_nxt.a_wr  = i_req_addr;
      ctrl_nxt.en_wr = i_req_chunk_en;
    end else begin
      ctrl_nxt.a_rd  = i_req_addr;
      ctrl_nxt.en_rd = i_req_chunk_en;
    end
  end

  // control word register, valid for one cycle after the sampling edge
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_ctrl.ctrl <= '0;
    end else begin
      o_ctrl.ctrl <= ctrl_nxt;
    end
  end

  // write data rides alongside the control word
  always_ff @(posedge clk) begin
    if (i_req_v && i_req_wr) begin
      o_ctrl.w_data <= i_wr_data;
    end
  end

  // an accepted request shows up next cycle on exactly one sector and half
  a_one_sector: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_req_v |=> o_ctrl.ctrl.v &&
      $onehot({o_ctrl.ctrl.sect_en_upper, o_ctrl.ctrl.sect_en_lower}));

endmodule

`default_nettype wire

/* pm_chunk_sram.sv */
// behavioral chunk sram

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_chunk_sram (
  input  logic             clk,
  input  logic             i_rst_n,
  input  pm_pkg::pm_addr_t i_addr,
  input  logic             i_rd_en,
  input  logic             i_wr_en,
  input  pm_pkg::pm_data_t i_wr_data,
  output pm_pkg::pm_data_t o_rd_data,
  output logic             o_rd_valid
);

  import pm_pkg::*;

  localparam int DEPTH = 2 ** `PM_ADDR_W;

  // storage array
  pm_data_t mem [DEPTH];

  // ----------------------------------------------------------------------
  // single port access
  // ----------------------------------------------------------------------

  // write lands on the edge that ends the request cycle
  // read data is registered, one cycle latency
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_addr] <= i_wr_data;
    end
    if (i_rd_en) begin
      o_rd_data <= mem[i_addr];
    end
  end

  // read valid strobe, one cycle behind rd_en
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_en;
    end
  end

  // bank decode must never ask for both at once on one port
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_rd_en && i_wr_en));

endmodule

`default_nettype wire

/* pm_bank.sv */
// packet memory sector bank

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_bank #(
  parameter int SECTOR_ID = 0
) (
  input  logic              clk,
  input  logic              i_rst_n,
  pm_ctrl_if.bank           i_ctrl,
  output pm_pkg::pm_rd_bus_t o_r_bus
);

  import pm_pkg::*;

  localparam int N_LOWER = `PM_N_CHUNKS / 2;

  // per-chunk sram controls
  pm_addr_t [`PM_N_CHUNKS-1:0] chunk_addr;
  pm_chunk_mask_t              chunk_rd_en;
  pm_chunk_mask_t              chunk_wr_en;
  pm_chunk_mask_t              chunk_rd_valid;
  pm_data_t [`PM_N_CHUNKS-1:0] chunk_rd_data;

  // this bank's select and direction, per half
  logic hit_lower;
  logic hit_upper;
  logic wr_lower;
  logic wr_upper;

  // ----------------------------------------------------------------------
  // control word decode
  // ----------------------------------------------------------------------
  always_comb begin
    logic hit;
    logic wr;

    hit_lower = i_ctrl.ctrl.v & i_ctrl.ctrl.sect_en_lower[SECTOR_ID];
    hit_upper = i_ctrl.ctrl.v & i_ctrl.ctrl.sect_en_upper[SECTOR_ID];
    wr_lower  = i_ctrl.ctrl.sect_rw_lower[SECTOR_ID];
    wr_upper  = i_ctrl.ctrl.sect_rw_upper[SECTOR_ID];

    chunk_rd_en = '0;
    chunk_wr_en = '0;

    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      // address defaults to the read side
      chunk_addr[i] = i_ctrl.ctrl.a_rd;

      // pick the half this chunk belongs to
      if (i < N_LOWER) begin
        hit = hit_lower;
        wr  = wr_lower;
      end else begin
        hit = hit_upper;
        wr  = wr_upper;
      end

      if (hit) begin
        if (wr) begin
          // write steers the address over to a_wr
          chunk_addr[i]  = i_ctrl.ctrl.a_wr;
          chunk_wr_en[i] = i_ctrl.ctrl.en_wr[i];
        end else begin
          chunk_rd_en[i] = i_ctrl.ctrl.en_rd[i];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // chunk srams
  // ----------------------------------------------------------------------
  for (genvar chunk_i = 0; chunk_i < `PM_N_CHUNKS; chunk_i++) begin : g_chunk
    pm_chunk_sram u_chunk_sram (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_addr     (chunk_addr[chunk_i]),
      .i_rd_en    (chunk_rd_en[chunk_i]),
      .i_wr_en    (chunk_wr_en[chunk_i]),
      .i_wr_data  (i_ctrl.w_data[chunk_i]),
      .o_rd_data  (chunk_rd_data[chunk_i]),
      .o_rd_valid (chunk_rd_valid[chunk_i])
    );
  end

  // ----------------------------------------------------------------------
  // read return bus
  // ----------------------------------------------------------------------

  // straight from the srams, no extra stage here
  always_comb begin
    o_r_bus.v = chunk_rd_valid;
    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      o_r_bus.d[i] = chunk_rd_data[i];
    end
  end

endmodule

`default_nettype wire

/* pm_rd_merge.sv */
// packet memory read merger

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_rd_merge (
  input  logic                                    clk,
  input  logic                                    i_rst_n,
  input  pm_pkg::pm_rd_bus_t                      i_bus0,
  input  pm_pkg::pm_rd_bus_t                      i_bus1,
  output pm_pkg::pm_chunk_mask_t                  o_rd_v,
  output logic [`PM_N_CHUNKS-1:0][`PM_DATA_W-1:0] o_rd_data
);

  import pm_pkg::*;

  pm_chunk_mask_t              mrg_v;
  pm_data_t [`PM_N_CHUNKS-1:0] mrg_d;

  // ----------------------------------------------------------------------
  // per chunk merge
  // ----------------------------------------------------------------------

  // at most one bank answers a chunk, so take whichever is valid
  always_comb begin
    mrg_v = i_bus0.v | i_bus1.v;
    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      mrg_d[i] = i_bus1.v[i] ? i_bus1.d[i] : i_bus0.d[i];
    end
  end

  // ----------------------------------------------------------------------
  // output stage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_rd_v <= '0;
    end else begin
      o_rd_v <= mrg_v;
    end
  end

  // data is payload only
  always_ff @(posedge clk) begin
    o_rd_data <= mrg_d;
  end

  // the two sector banks never return on the same chunk together
  a_no_collide: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_bus0.v & i_bus1.v) == '0);

endmodule

`default_nettype wire

/* pm_top.sv */
// packet memory top level

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_top (
  input  logic                                    clk,
  input  logic                                    i_rst_n,
  input  logic                                    i_req_v,
  input  logic                                    i_req_wr,
  input  logic [$clog2(`PM_N_SECTORS)-1:0]        i_req_sector,
  input  logic                                    i_req_upper,
  input  logic [`PM_ADDR_W-1:0]                   i_req_addr,
  input  logic [`PM_N_CHUNKS-1:0]                 i_req_chunk_en,
  input  logic [`PM_N_CHUNKS-1:0][`PM_DATA_W-1:0] i_wr_data,
  output logic [`PM_N_CHUNKS-1:0]                 o_rd_v,
  output logic [`PM_N_CHUNKS-1:0][`PM_DATA_W-1:0] o_rd_data
);

  import pm_pkg::*;

  // read returns from each sector
  pm_rd_bus_t r_bus0;
  pm_rd_bus_t r_bus1;

  // control word fans out to both banks
  pm_ctrl_if ctrl_if ();

  // ----------------------------------------------------------------------
  // request path
  // ----------------------------------------------------------------------
  pm_cmd_gen u_cmd_gen (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_req_v        (i_req_v),
    .i_req_wr       (i_req_wr),
    .i_req_sector   (i_req_sector),
    .i_req_upper    (i_req_upper),
    .i_req_addr     (i_req_addr),
    .i_req_chunk_en (i_req_chunk_en),
    .i_wr_data      (i_wr_data),
    .o_ctrl         (ctrl_if.gen)
  );

  // sector banks side by side
  pm_bank #(.SECTOR_ID(0)) u_bank0 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_ctrl  (ctrl_if.bank),
    .o_r_bus (r_bus0)
  );

  pm_bank #(.SECTOR_ID(1)) u_bank1 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_ctrl  (ctrl_if.bank),
    .o_r_bus (r_bus1)
  );

  // ----------------------------------------------------------------------
  // read return path
  // ----------------------------------------------------------------------
  pm_rd_merge u_rd_merge (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_bus0    (r_bus0),
    .i_bus1    (r_bus1),
    .o_rd_v    (o_rd_v),
    .o_rd_data (o_rd_data)
  );

endmodule

`default_nettype wire

/* tb_pm_top.sv */
// packet memory testbench

`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module tb_pm_top;

  import pm_pkg::*;

  localparam int SECT_W = $clog2(`PM_N_SECTORS);
  localparam int DEPTH  = 2 ** `PM_ADDR_W;

  // one word per chunk, same packing as the top-level data ports
  typedef pm_data_t [`PM_N_CHUNKS-1:0] line_t;

  logic              clk;
  logic              rst_n;
  logic              req_v;
  logic              req_wr;
  logic [SECT_W-1:0] req_sector;
  logic              req_upper;
  pm_addr_t          req_addr;
  pm_chunk_mask_t    req_chunk_en;
  line_t             wr_data;
  pm_chunk_mask_t    rd_v;
  line_t             rd_data;

  // reference memory, sector by chunk by address
  pm_data_t ref_mem [`PM_N_SECTORS][`PM_N_CHUNKS][DEPTH];

  // expected read returns, oldest first
  int             due_q[$];
  pm_chunk_mask_t mask_q[$];
  line_t          data_q[$];

  int cyc;
  int seed;
  int chk_cnt;
  int err_cnt;

  pm_top pm_top_inst (
    .clk            (clk),
    .i_rst_n        (rst_n),
    .i_req_v        (req_v),
    .i_req_wr       (req_wr),
    .i_req_sector   (req_sector),
    .i_req_upper    (req_upper),
    .i_req_addr     (req_addr),
    .i_req_chunk_en (req_chunk_en),
    .i_wr_data      (wr_data),
    .o_rd_v         (rd_v),
    .o_rd_data      (rd_data)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // chunks that belong to the lower or the upper half
  function automatic pm_chunk_mask_t half_mask(input logic up);
    pm_chunk_mask_t m;
    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      m[i] = up ? (i >= `PM_N_CHUNKS / 2) : (i < `PM_N_CHUNKS / 2);
    end
    return m;
  endfunction

  function automatic line_t rand_line();
    line_t d;
    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      d[i] = pm_data_t'($random(seed));
    end
    return d;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // drive a write and update the model for the chunks it really touches
  task automatic issue_write(input int s, input logic up, input int a,
                             input pm_chunk_mask_t en, input line_t d);
    pm_chunk_mask_t m;
    m = en & half_mask(up);
    @(posedge clk);
    req_v        <= 1'b1;
    req_wr       <= 1'b1;
    req_sector   <= SECT_W'(s);
    req_upper    <= up;
    req_addr     <= pm_addr_t'(a);
    req_chunk_en <= en;
    wr_data      <= d;
    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      if (m[i]) begin
        ref_mem[s][i][a] = d[i];
      end
    end
  endtask

  // drive a read and queue what should come back
  task automatic issue_read(input int s, input logic up, input int a,
                            input pm_chunk_mask_t en);
    pm_chunk_mask_t m;
    line_t          e;
    m = en & half_mask(up);
    e = '0;
    for (int i = 0; i < `PM_N_CHUNKS; i++) begin
      if (m[i]) begin
        e[i] = ref_mem[s][i][a];
      end
    end
    @(posedge clk);
    req_v        <= 1'b1;
    req_wr       <= 1'b0;
    req_sector   <= SECT_W'(s);
    req_upper    <= up;
    req_addr     <= pm_addr_t'(a);
    req_chunk_en <= en;
    // sampled next edge, seen on o_rd_v three edges after that
    if (m != '0) begin
      due_q.push_back(cyc + 4);
      mask_q.push_back(m);
      data_q.push_back(e);
    end
  endtask

  // go idle until every queued read has returned
  task automatic drain();
    int n;
    n = 0;
    while (due_q.size() > 0 && n < 16) begin
      @(posedge clk);
      req_v <= 1'b0;
      n++;
    end
    if (due_q.size() > 0) begin
      err_cnt++;
      $display("error: %0d read results never came back", due_q.size());
      due_q.delete();
      mask_q.delete();
      data_q.delete();
    end
    repeat (2) begin
      @(posedge clk);
      req_v <= 1'b0;
    end
  endtask

  // ----------------------------------------------------------------------
  // read return monitor
  // ----------------------------------------------------------------------

  // values read here are the ones held just before this edge
  task automatic check_return();
    pm_chunk_mask_t m;
    line_t          e;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      due_q.delete(0);
      m = mask_q.pop_front();
      e = data_q.pop_front();
      chk_cnt++;
      if (rd_v !== m) begin
        err_cnt++;
        $display("Fail %0t: o_rd_v %b, expected %b", $time, rd_v, m);
      end
      for (int i = 0; i < `PM_N_CHUNKS; i++) begin
        if (m[i]) begin
          chk_cnt++;
          if (rd_data[i] !== e[i]) begin
            err_cnt++;
            $display("Fail %0t: chunk %0d data %h, expected %h", $time, i, rd_data[i], e[i]);
          end
        end
      end
    end else if (rd_v !== '0) begin
      err_cnt++;
      $display("Fail %0t: o_rd_v %b with no read due", $time, rd_v);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (rst_n) begin
      check_return();
    end
  end

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  // no read valid while in reset or while idle after it
  task automatic test_reset();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      // first edge still shows pre-reset state
      if (i > 0) begin
        chk_cnt++;
        if (rd_v !== '0) begin
          err_cnt++;
          $display("Fail %0t: o_rd_v %b during reset", $time, rd_v);
        end
      end
    end
    rst_n <= 1'b1;
    repeat (6) begin
      @(posedge clk);
      chk_cnt++;
      if (rd_v !== '0) begin
        err_cnt++;
        $display("Fail %0t: o_rd_v %b while idle", $time, rd_v);
      end
    end
  endtask

  // every sector and half, full mask
  task automatic test_basic();
    for (int s = 0; s < `PM_N_SECTORS; s++) begin
      for (int up = 0; up < 2; up++) begin
        issue_write(s, up[0], 10 + 2 * s + up, '1, rand_line());
        issue_read(s, up[0], 10 + 2 * s + up, '1);
      end
    end
    drain();
  endtask

  // only enabled chunks change, only enabled chunks return
  task automatic test_partial();
    issue_write(0, 1'b0, 5, 4'b1111, rand_line());
    issue_write(0, 1'b0, 5, 4'b0001, rand_line());
    issue_read(0, 1'b0, 5, 4'b0011);
    issue_read(0, 1'b0, 5, 4'b0010);
    issue_write(1, 1'b1, 40, 4'b1111, rand_line());
    issue_write(1, 1'b1, 40, 4'b1000, rand_line());
    issue_read(1, 1'b1, 40, 4'b0100);
    issue_read(1, 1'b1, 40, 4'b1100);
    drain();
  endtask

  // same address and half, one word per sector
  task automatic test_isolation();
    issue_write(0, 1'b1, 9, '1, rand_line());
    issue_write(1, 1'b1, 9, '1, rand_line());
    issue_read(0, 1'b1, 9, '1);
    issue_read(1, 1'b1, 9, '1);
    drain();
  endtask

  // fill a small window, then a read on every cycle
  task automatic test_back_to_back();
    for (int a = 0; a < 16; a++) begin
      for (int s = 0; s < `PM_N_SECTORS; s++) begin
        issue_write(s, 1'b0, a, '1, rand_line());
        issue_write(s, 1'b1, a, '1, rand_line());
      end
    end
    for (int k = 0; k < 64; k++) begin
      issue_read(rand_below(`PM_N_SECTORS), rand_below(2) == 1, rand_below(16), '1);
    end
    drain();
  endtask

  // read right behind a write to the same place
  task automatic test_write_then_read();
    for (int k = 0; k < 2; k++) begin
      issue_write(1, 1'b0, 33, '1, rand_line());
      issue_read(1, 1'b0, 33, '1);
      issue_write(0, 1'b1, 33, '1, rand_line());
      issue_read(0, 1'b1, 33, '1);
    end
    drain();
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n        = 1'b0;
    req_v        = 1'b0;
    req_wr       = 1'b0;
    req_sector   = '0;
    req_upper    = 1'b0;
    req_addr     = '0;
    req_chunk_en = '0;
    wr_data      = '0;
    cyc          = 0;
    seed         = 91;
    chk_cnt      = 0;
    err_cnt      = 0;
    test_reset();
    test_basic();
    test_partial();
    test_isolation();
    test_back_to_back();
    test_write_then_read();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog, the whole run needs roughly 300 cycles
  initial begin
    #200000;
    $display("timeout: the run did not finish within 200 us");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
pm_pkg.sv
pm_ctrl_if.sv
pm_cmd_gen.sv
pm_chunk_sram.sv
pm_bank.sv
pm_rd_merge.sv
pm_top.sv
tb_pm_top.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_pm_top
FILELIST := src.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
